/* rtl/uc_clint.sv */
`timescale 1ns/10ps
`default_nettype none

module uc_clint
  import uc_mem_pkg::*;
  (  input  wire      clk_i
   , input  wire      arst_n_i

   , input  mem_msg_t cmd_i
   , input  wire      cmd_v_i
   , output logic     cmd_ready_o

   , output mem_msg_t resp_o
   , output logic     resp_v_o
   , input  wire      resp_yumi_i

   , output logic     timer_irq_o
   , output logic     software_irq_o
   );

  clint_off_t offset;
  data_t      mtime_r;
  data_t      mtimecmp_r;
  data_t      rd_data;
  logic       msip_r;
  mem_msg_t   resp_r;
  logic       resp_v_r;
  logic       accept;
  logic       wr;

  assign cmd_ready_o = ~resp_v_r;
  assign accept      = cmd_v_i & cmd_ready_o;
  assign wr          = accept & (cmd_i.op == e_mem_wr);
  assign offset      = cmd_i.addr[$bits(clint_off_t)-1:0];

  always_comb
  begin
    case (offset)
      clint_msip_c:     rd_data = data_t'(msip_r);
      clint_mtimecmp_c: rd_data = mtimecmp_r;
      clint_mtime_c:    rd_data = mtime_r;
      default:          rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      mtime_r    <= '0;
      mtimecmp_r <= '1;
      msip_r     <= 1'b0;
      resp_v_r   <= 1'b0;
    end
    else
    begin
      // A write to mtime takes priority over the tick
      if (wr && (offset == clint_mtime_c))
        mtime_r <= cmd_i.data;
      else
        mtime_r <= mtime_r + data_t'(1);
      if (wr && (offset == clint_mtimecmp_c))
        mtimecmp_r <= cmd_i.data;
      if (wr && (offset == clint_msip_c))
        msip_r <= cmd_i.data[0];
      resp_v_r <= accept | (resp_v_r & ~resp_yumi_i);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      resp_r.op     <= cmd_i.op;
      resp_r.lce_id <= cmd_i.lce_id;
      resp_r.addr   <= cmd_i.addr;
      resp_r.data   <= (cmd_i.op == e_mem_wr) ? cmd_i.data : rd_data;
    end
  end

  assign resp_o         = resp_r;
  assign resp_v_o       = resp_v_r;
  assign timer_irq_o    = (mtime_r >= mtimecmp_r);
  assign software_irq_o = msip_r;

  // Command router only dispatches here while the response slot is free
  cmd_ready_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cmd_v_i |-> cmd_ready_o);

endmodule

`default_nettype wire

/* rtl/uc_cmd_router.sv */
`timescale 1ns/10ps
`default_nettype none

module uc_cmd_router
  import uc_mem_pkg::*;
  #(parameter int requesters_p = 3)
  (  input  mem_msg_t [requesters_p-1:0] cmd_i
   , input  wire      [requesters_p-1:0] cmd_v_i
   , output logic     [requesters_p-1:0] cmd_yumi_o

   , input  wire                         clint_ready_i
   , input  wire                         loop_ready_i
   , input  wire                         io_ready_i
   , input  wire                         mem_ready_i

   , output mem_msg_t                    cmd_o
   , output logic                        clint_v_o
   , output logic                        loop_v_o
   , output logic                        io_v_o
   , output logic                        mem_v_o
   );

  logic                    all_ready;
  logic [requesters_p-1:0] grant;
  logic                    any_grant;
  dev_id_t                 dev;
  dest_e                   dest;

  // A single busy destination holds back every port
  assign all_ready = clint_ready_i & loop_ready_i & io_ready_i & mem_ready_i;

  // Scan from the top so the lowest valid index wins
  always_comb
  begin
    grant = '0;
    cmd_o = '0;
    if (all_ready)
    begin
      for (int i = requesters_p - 1; i >= 0; i--)
      begin
        if (cmd_v_i[i])
        begin
          grant    = '0;
          grant[i] = 1'b1;
          cmd_o    = cmd_i[i];
        end
      end
    end
  end

  assign cmd_yumi_o = grant;
  assign any_grant  = |grant;

  assign dev = cmd_o.addr[dev_lsb_c +: $bits(dev_id_t)];

  always_comb
  begin
    if (cmd_o.addr >= dram_base_c)
      dest = e_dest_mem;
    else
    begin
      case (dev)
        clint_dev_c: dest = e_dest_clint;
        host_dev_c:  dest = e_dest_io;
        cache_dev_c: dest = e_dest_mem;
        default:     dest = e_dest_loop;
      endcase
    end
  end

  assign clint_v_o = any_grant & (dest == e_dest_clint);
  assign loop_v_o  = any_grant & (dest == e_dest_loop);
  assign io_v_o    = any_grant & (dest == e_dest_io);
  assign mem_v_o   = any_grant & (dest == e_dest_mem);

endmodule

`default_nettype wire

/* rtl/uc_loopback.sv */
`timescale 1ns/10ps
`default_nettype none

module uc_loopback
  import uc_mem_pkg::*;
  (  input  wire      clk_i
   , input  wire      arst_n_i

   , input  mem_msg_t cmd_i
   , input  wire      cmd_v_i
   , output logic     cmd_ready_o

   , output mem_msg_t resp_o
   , output logic     resp_v_o
   , input  wire      resp_yumi_i
   );

  mem_msg_t resp_r;
  logic     resp_v_r;
  logic     accept;

  assign cmd_ready_o = ~resp_v_r;
  assign accept      = cmd_v_i & cmd_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      resp_v_r <= 1'b0;
    else
      resp_v_r <= accept | (resp_v_r & ~resp_yumi_i);
  end

  // Same header back, data zeroed
  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      resp_r      <= cmd_i;
      resp_r.data <= '0;
    end
  end

  assign resp_o   = resp_r;
  assign resp_v_o = resp_v_r;

endmodule

`default_nettype wire

/* rtl/uc_mem_pkg.sv */
`default_nettype none

package uc_mem_pkg;

  // Widths that carry a meaning
  typedef logic [39:0] paddr_t;
  typedef logic [63:0] data_t;
  typedef logic [1:0]  lce_id_t;
  typedef logic [3:0]  dev_id_t;
  typedef logic [15:0] clint_off_t;

  typedef enum logic
  {
    e_mem_rd,
    e_mem_wr
  } mem_op_e;

  // One memory message, command or response
  typedef struct packed
  {
    mem_op_e op;
    lce_id_t lce_id;
    paddr_t  addr;
    data_t   data;
  } mem_msg_t;

  // Local memory map
  localparam paddr_t  dram_base_c = 40'h00_8000_0000;
  localparam int      dev_lsb_c   = 20;

  localparam dev_id_t clint_dev_c = 4'd1;
  localparam dev_id_t host_dev_c  = 4'd2;
  localparam dev_id_t cache_dev_c = 4'd3;

  // CLINT register offsets, address bits 15 to 0
  localparam clint_off_t clint_msip_c     = 16'h0000;
  localparam clint_off_t clint_mtimecmp_c = 16'h4000;
  localparam clint_off_t clint_mtime_c    = 16'hBFF8;

  // Dispatch targets of the command path
  typedef enum logic [1:0]
  {
    e_dest_clint,
    e_dest_io,
    e_dest_mem,
    e_dest_loop
  } dest_e;

endpackage

`default_nettype wire

/* rtl/uc_resp_router.sv */
`timescale 1ns/10ps
`default_nettype none

module uc_resp_router
  import uc_mem_pkg::*;
  #(parameter int requesters_p = 3)
  (  input  mem_msg_t                    clint_resp_i
   , input  wire                         clint_v_i
   , output logic                        clint_yumi_o

   , input  mem_msg_t                    loop_resp_i
   , input  wire                         loop_v_i
   , output logic                        loop_yumi_o

   , input  mem_msg_t                    io_resp_i
   , input  wire                         io_v_i
   , output logic                        io_yumi_o

   , input  mem_msg_t                    mem_resp_i
   , input  wire                         mem_v_i
   , output logic                        mem_yumi_o

   , input  wire      [requesters_p-1:0] fifo_ready_i
   , output mem_msg_t                    resp_o
   , output logic     [requesters_p-1:0] resp_v_o
   );

  logic       all_ready;
  logic [3:0] req;
  logic [3:0] grant;

  assign all_ready = &fifo_ready_i;

  // Bit 0 is the CLINT, highest priority
  assign req   = {mem_v_i, io_v_i, loop_v_i, clint_v_i};
  assign grant = all_ready ? (req & (~req + 4'd1)) : 4'd0;

  assign {mem_yumi_o, io_yumi_o, loop_yumi_o, clint_yumi_o} = grant;

  always_comb
  begin
    case (grant)
      4'b0001: resp_o = clint_resp_i;
      4'b0010: resp_o = loop_resp_i;
      4'b0100: resp_o = io_resp_i;
      default: resp_o = mem_resp_i;
    endcase
  end

  for (genvar i = 0; i < requesters_p; i++)
  begin : g_steer
    assign resp_v_o[i] = (|grant) & (resp_o.lce_id == lce_id_t'(i));
  end

  // A response for a missing requester would be lost
  lce_range_a: assert final (!(|grant) || (int'(resp_o.lce_id) < requesters_p));

endmodule

`default_nettype wire

/* rtl/uc_two_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module uc_two_fifo
  import uc_mem_pkg::*;
  (  input  wire      clk_i
   , input  wire      arst_n_i

   , input  mem_msg_t data_i
   , input  wire      v_i
   , output logic     ready_o

   , output mem_msg_t data_o
   , output logic     v_o
   , input  wire      yumi_i
   );

  mem_msg_t slot_r [2];
  logic     wptr_r;
  logic     rptr_r;
  logic     full_r;
  logic     enq;

  assign enq     = v_i & ready_o;
  assign ready_o = ~full_r;
  // Pointers differ with one entry and match when empty or full
  assign v_o     = full_r | (wptr_r != rptr_r);
  assign data_o  = slot_r[rptr_r];

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wptr_r <= 1'b0;
      rptr_r <= 1'b0;
      full_r <= 1'b0;
    end
    else
    begin
      if (enq)
        wptr_r <= ~wptr_r;
      if (yumi_i)
        rptr_r <= ~rptr_r;
      full_r <= (full_r & ~yumi_i) | (enq & ~yumi_i & (wptr_r != rptr_r));
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (enq)
      slot_r[wptr_r] <= data_i;
  end

  yumi_valid_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    yumi_i |-> v_o);

endmodule

`default_nettype wire

/* rtl/uc_uncore.sv */
`timescale 1ns/10ps
`default_nettype none

module uc_uncore
  import uc_mem_pkg::*;
  #(parameter int requesters_p = 3)
  (  input  wire                         clk_i
   , input  wire                         arst_n_i

   // Requester ports, 0 icache, 1 dcache, 2 incoming I/O
   , input  mem_msg_t [requesters_p-1:0] proc_cmd_i
   , input  wire      [requesters_p-1:0] proc_cmd_v_i
   , output logic     [requesters_p-1:0] proc_cmd_ready_o

   , output mem_msg_t [requesters_p-1:0] proc_resp_o
   , output logic     [requesters_p-1:0] proc_resp_v_o
   , input  wire      [requesters_p-1:0] proc_resp_yumi_i

   // Outgoing I/O
   , output mem_msg_t                    io_cmd_o
   , output logic                        io_cmd_v_o
   , input  wire                         io_cmd_ready_i

   , input  mem_msg_t                    io_resp_i
   , input  wire                         io_resp_v_i
   , output logic                        io_resp_yumi_o

   // Main memory, no L2 in the path
   , output mem_msg_t                    mem_cmd_o
   , output logic                        mem_cmd_v_o
   , input  wire                         mem_cmd_ready_i

   , input  mem_msg_t                    mem_resp_i
   , input  wire                         mem_resp_v_i
   , output logic                        mem_resp_yumi_o

   , output logic                        timer_irq_o
   , output logic                        software_irq_o
   );

  mem_msg_t [requesters_p-1:0] cmd_fifo_lo;
  logic     [requesters_p-1:0] cmd_fifo_v_lo;
  logic     [requesters_p-1:0] cmd_fifo_yumi_li;

  mem_msg_t                    resp_fifo_li;
  logic     [requesters_p-1:0] resp_fifo_v_li;
  logic     [requesters_p-1:0] resp_fifo_ready_lo;

  mem_msg_t dev_cmd_lo;
  logic     clint_cmd_v_li;
  logic     clint_cmd_ready_lo;
  logic     loop_cmd_v_li;
  logic     loop_cmd_ready_lo;

  mem_msg_t clint_resp_lo;
  logic     clint_resp_v_lo;
  logic     clint_resp_yumi_li;
  mem_msg_t loop_resp_lo;
  logic     loop_resp_v_lo;
  logic     loop_resp_yumi_li;

  for (genvar i = 0; i < requesters_p; i++)
  begin : g_port
    uc_two_fifo u_cmd_fifo
      (.clk_i(clk_i)
       ,.arst_n_i(arst_n_i)
       ,.data_i(proc_cmd_i[i])
       ,.v_i(proc_cmd_v_i[i])
       ,.ready_o(proc_cmd_ready_o[i])
       ,.data_o(cmd_fifo_lo[i])
       ,.v_o(cmd_fifo_v_lo[i])
       ,.yumi_i(cmd_fifo_yumi_li[i])
       );

    uc_two_fifo u_resp_fifo
      (.clk_i(clk_i)
       ,.arst_n_i(arst_n_i)
       ,.data_i(resp_fifo_li)
       ,.v_i(resp_fifo_v_li[i])
       ,.ready_o(resp_fifo_ready_lo[i])
       ,.data_o(proc_resp_o[i])
       ,.v_o(proc_resp_v_o[i])
       ,.yumi_i(proc_resp_yumi_i[i])
       );
  end

  uc_cmd_router #(.requesters_p(requesters_p)) u_cmd_router
    (.cmd_i(cmd_fifo_lo)
     ,.cmd_v_i(cmd_fifo_v_lo)
     ,.cmd_yumi_o(cmd_fifo_yumi_li)
     ,.clint_ready_i(clint_cmd_ready_lo)
     ,.loop_ready_i(loop_cmd_ready_lo)
     ,.io_ready_i(io_cmd_ready_i)
     ,.mem_ready_i(mem_cmd_ready_i)
     ,.cmd_o(dev_cmd_lo)
     ,.clint_v_o(clint_cmd_v_li)
     ,.loop_v_o(loop_cmd_v_li)
     ,.io_v_o(io_cmd_v_o)
     ,.mem_v_o(mem_cmd_v_o)
     );

  // Every destination sees the selected command
  assign io_cmd_o  = dev_cmd_lo;
  assign mem_cmd_o = dev_cmd_lo;

  uc_clint u_clint
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.cmd_i(dev_cmd_lo)
     ,.cmd_v_i(clint_cmd_v_li)
     ,.cmd_ready_o(clint_cmd_ready_lo)
     ,.resp_o(clint_resp_lo)
     ,.resp_v_o(clint_resp_v_lo)
     ,.resp_yumi_i(clint_resp_yumi_li)
     ,.timer_irq_o(timer_irq_o)
     ,.software_irq_o(software_irq_o)
     );

  uc_loopback u_loopback
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.cmd_i(dev_cmd_lo)
     ,.cmd_v_i(loop_cmd_v_li)
     ,.cmd_ready_o(loop_cmd_ready_lo)
     ,.resp_o(loop_resp_lo)
     ,.resp_v_o(loop_resp_v_lo)
     ,.resp_yumi_i(loop_resp_yumi_li)
     );

  uc_resp_router #(.requesters_p(requesters_p)) u_resp_router
    (.clint_resp_i(clint_resp_lo)
     ,.clint_v_i(clint_resp_v_lo)
     ,.clint_yumi_o(clint_resp_yumi_li)
     ,.loop_resp_i(loop_resp_lo)
     ,.loop_v_i(loop_resp_v_lo)
     ,.loop_yumi_o(loop_resp_yumi_li)
     ,.io_resp_i(io_resp_i)
     ,.io_v_i(io_resp_v_i)
     ,.io_yumi_o(io_resp_yumi_o)
     ,.mem_resp_i(mem_resp_i)
     ,.mem_v_i(mem_resp_v_i)
     ,.mem_yumi_o(mem_resp_yumi_o)
     ,.fifo_ready_i(resp_fifo_ready_lo)
     ,.resp_o(resp_fifo_li)
     ,.resp_v_o(resp_fifo_v_li)
     );

endmodule

`default_nettype wire

/* testbench/tb_uc_uncore.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_uc_uncore
  import uc_mem_pkg::*;
  ;

  logic            clk_i;
  logic            arst_n_i;
  mem_msg_t [2:0]  proc_cmd_i;
  logic     [2:0]  proc_cmd_v_i;
  logic     [2:0]  proc_cmd_ready_o;
  mem_msg_t [2:0]  proc_resp_o;
  logic     [2:0]  proc_resp_v_o;
  logic     [2:0]  proc_resp_yumi_i;
  logic            timer_irq_o;
  logic            software_irq_o;

  // Index 0 is the I/O side, index 1 main memory
  mem_msg_t [1:0]  dev_cmd;
  logic     [1:0]  dev_cmd_v;
  logic     [1:0]  dev_ready;
  mem_msg_t [1:0]  dev_rsp;
  logic     [1:0]  dev_rsp_v;
  logic     [1:0]  dev_rsp_yumi;

  mem_msg_t        send_q [3][$];
  mem_msg_t        exp_cmd [2][3][$];
  mem_msg_t        exp_rsp [3][$];
  mem_msg_t        dev_q [2][$];
  int unsigned     dev_due [2][$];

  mem_msg_t        clint_rsp;
  int              clint_rsp_port;
  int              clint_rsp_cnt = 0;
  logic            rand_bp = 1'b0;
  logic [31:0]     lfsr_r = 32'h5877;
  int unsigned     cycle = 0;
  int              errors = 0;
  int              test_errors_at = 0;
  int              tests_run = 0;
  int              tests_failed = 0;

  uc_uncore #(.requesters_p(3)) u_uc_uncore
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.proc_cmd_i(proc_cmd_i)
     ,.proc_cmd_v_i(proc_cmd_v_i)
     ,.proc_cmd_ready_o(proc_cmd_ready_o)
     ,.proc_resp_o(proc_resp_o)
     ,.proc_resp_v_o(proc_resp_v_o)
     ,.proc_resp_yumi_i(proc_resp_yumi_i)
     ,.io_cmd_o(dev_cmd[0])
     ,.io_cmd_v_o(dev_cmd_v[0])
     ,.io_cmd_ready_i(dev_ready[0])
     ,.io_resp_i(dev_rsp[0])
     ,.io_resp_v_i(dev_rsp_v[0])
     ,.io_resp_yumi_o(dev_rsp_yumi[0])
     ,.mem_cmd_o(dev_cmd[1])
     ,.mem_cmd_v_o(dev_cmd_v[1])
     ,.mem_cmd_ready_i(dev_ready[1])
     ,.mem_resp_i(dev_rsp[1])
     ,.mem_resp_v_i(dev_rsp_v[1])
     ,.mem_resp_yumi_o(dev_rsp_yumi[1])
     ,.timer_irq_o(timer_irq_o)
     ,.software_irq_o(software_irq_o)
     );

  initial
  begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i)
    cycle <= cycle + 1;

  task automatic report_mismatch(string sig, logic [127:0] got, logic [127:0] exp);
    $display("FAILED at %0t: %s got %h expected %h", $time, sig, got, exp);
    errors++;
  endtask

  task automatic report_failure(string msg);
    $display("ERROR at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic abort_run(string msg);
    $display("ERROR at %0t: %s", $time, msg);
    $display("TESTS FAILED");
    $finish;
  endtask

  // Galois LFSR, one step per bit
  function automatic logic [63:0] rand_bits(int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[62:0], lfsr_r[0]};
      lfsr_r = {1'b0, lfsr_r[31:1]} ^ (lfsr_r[0] ? 32'h8020_0003 : 32'h0);
    end
    return v;
  endfunction

  // High three times in four under back-pressure, always high otherwise
  function automatic logic coin(logic bp);
    return bp ? (rand_bits(2) != 64'd0) : 1'b1;
  endfunction

  function automatic data_t read_pattern(paddr_t a);
    return {a[31:0], 32'h0} ^ {24'h0, a} ^ 64'h5A5A_0000_C3C3_0000;
  endfunction

  function automatic mem_msg_t model_resp(mem_msg_t m);
    mem_msg_t r;
    r = m;
    if (m.op == e_mem_rd)
      r.data = read_pattern(m.addr);
    return r;
  endfunction

  function automatic dest_e expect_dest(paddr_t a);
    if (a >= dram_base_c)
      return e_dest_mem;
    case (a[23:20])
      clint_dev_c: return e_dest_clint;
      host_dev_c:  return e_dest_io;
      cache_dev_c: return e_dest_mem;
      default:     return e_dest_loop;
    endcase
  endfunction

  // Random local or DRAM address, CLINT left out
  function automatic paddr_t rand_addr();
    logic [1:0]  kind;
    dev_id_t     dev;
    logic [19:0] low;
    kind = 2'(rand_bits(2));
    low  = 20'(rand_bits(20));
    if (kind == 2'd0)
      return dram_base_c | paddr_t'(rand_bits(31));
    case (kind)
      2'd1:    dev = cache_dev_c;
      2'd2:    dev = host_dev_c;
      default: dev = 4'(rand_bits(4));
    endcase
    if (kind == 2'd3 && dev >= 4'd1 && dev <= 4'd3)
      dev = dev + 4'd8;
    return {16'h0, dev, low};
  endfunction

  task automatic issue(int port, mem_op_e op, paddr_t addr, data_t data);
    mem_msg_t m;
    mem_msg_t r;
    m.op     = op;
    m.lce_id = lce_id_t'(port);
    m.addr   = addr;
    m.data   = data;
    r        = m;
    case (expect_dest(addr))
      e_dest_io:
      begin
        exp_cmd[0][port].push_back(m);
        exp_rsp[port].push_back(model_resp(m));
      end
      e_dest_mem:
      begin
        exp_cmd[1][port].push_back(m);
        exp_rsp[port].push_back(model_resp(m));
      end
      e_dest_loop:
      begin
        r.data = '0;
        exp_rsp[port].push_back(r);
      end
      default:
      begin
      end
    endcase
    send_q[port].push_back(m);
  endtask

  task automatic take_dest_cmd(int d, mem_msg_t m);
    int       p;
    mem_msg_t e;
    p = int'(m.lce_id);
    if (p > 2 || exp_cmd[d][p].size() == 0)
      report_failure($sformatf("unexpected command on %s_cmd_o, address %h",
                               (d == 0) ? "io" : "mem", m.addr));
    else
    begin
      e = exp_cmd[d][p].pop_front();
      cmd_order_a: assert (m == e)
        else report_mismatch($sformatf("%s_cmd_o", (d == 0) ? "io" : "mem"), m, e);
    end
    dev_q[d].push_back(m);
    dev_due[d].push_back(cycle + int'(rand_bits(3)));
  endtask

  task automatic take_response(int p, mem_msg_t m);
    int hit;
    hit = -1;
    if (expect_dest(m.addr) == e_dest_clint)
    begin
      clint_rsp      = m;
      clint_rsp_port = p;
      clint_rsp_cnt++;
    end
    else
    begin
      for (int k = 0; k < exp_rsp[p].size(); k++)
      begin
        if (hit < 0 && exp_rsp[p][k] == m)
          hit = k;
      end
      rsp_known_a: assert (hit >= 0)
        else
        begin
          if (exp_rsp[p].size() != 0)
            report_mismatch($sformatf("proc_resp_o[%0d]", p), m, exp_rsp[p][0]);
          else
            report_failure($sformatf("response on port %0d with nothing outstanding", p));
        end
      if (hit >= 0)
        exp_rsp[p].delete(hit);
    end
  endtask

  // Requester ports, device models and response consumers
  always @(posedge clk_i)
  begin
    if (arst_n_i)
    begin
      for (int p = 0; p < 3; p++)
      begin
        if (proc_cmd_v_i[p] && proc_cmd_ready_o[p])
          void'(send_q[p].pop_front());
        proc_cmd_v_i[p] <= (send_q[p].size() != 0);
        if (send_q[p].size() != 0)
          proc_cmd_i[p] <= send_q[p][0];
        if (proc_resp_v_o[p] && proc_resp_yumi_i[p])
          take_response(p, proc_resp_o[p]);
        // Skip a cycle after each pop, the FIFO may have emptied
        proc_resp_yumi_i[p] <= proc_resp_v_o[p] && !proc_resp_yumi_i[p] && coin(rand_bp);
      end
      for (int d = 0; d < 2; d++)
      begin
        if (dev_rsp_v[d] && dev_rsp_yumi[d])
        begin
          void'(dev_q[d].pop_front());
          void'(dev_due[d].pop_front());
        end
        if (dev_cmd_v[d] && dev_ready[d])
          take_dest_cmd(d, dev_cmd[d]);
        dev_ready[d] <= coin(rand_bp);
        dev_rsp_v[d] <= (dev_q[d].size() != 0) && (dev_due[d][0] <= cycle);
        if (dev_q[d].size() != 0)
          dev_rsp[d] <= model_resp(dev_q[d][0]);
      end
    end
  end

  dest_ready_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (|dev_cmd_v) |-> ((&dev_ready) && u_uc_uncore.clint_cmd_ready_lo
                      && u_uc_uncore.loop_cmd_ready_lo))
    else report_failure("destination command issued while a destination was not ready");

  one_dest_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0({u_uc_uncore.clint_cmd_v_li, u_uc_uncore.loop_cmd_v_li, dev_cmd_v}))
    else report_failure("one command was dispatched to more than one destination");

  dev_yumi_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (dev_rsp_yumi & ~dev_rsp_v) == 2'b00)
    else report_failure("device response taken while its valid was low");

  function automatic logic traffic_idle();
    logic idle;
    idle = (proc_cmd_v_i == '0) && (proc_resp_v_o == '0) && (dev_rsp_v == '0);
    for (int p = 0; p < 3; p++)
    begin
      idle = idle && (send_q[p].size() == 0) && (exp_rsp[p].size() == 0)
             && (exp_cmd[0][p].size() == 0) && (exp_cmd[1][p].size() == 0);
    end
    return idle && (dev_q[0].size() == 0) && (dev_q[1].size() == 0);
  endfunction

  task automatic wait_idle(int limit);
    int t;
    t = 0;
    while (!traffic_idle())
    begin
      @(negedge clk_i);
      t++;
      if (t > limit)
        abort_run("traffic did not drain before the timeout");
    end
  endtask

  task automatic clint_access(int port, mem_op_e op, clint_off_t off, data_t wdata,
                              output mem_msg_t rsp);
    int     n0;
    int     t;
    paddr_t a;
    a  = {16'h0, clint_dev_c, 4'h0, off};
    n0 = clint_rsp_cnt;
    t  = 0;
    issue(port, op, a, wdata);
    while (clint_rsp_cnt == n0)
    begin
      @(negedge clk_i);
      t++;
      if (t > 200)
        abort_run("CLINT response did not arrive before the timeout");
    end
    rsp = clint_rsp;
    clint_hdr_a: assert (clint_rsp_port == port && rsp.lce_id == lce_id_t'(port)
                         && rsp.op == op && rsp.addr == a)
      else report_mismatch("CLINT response header", {rsp.op, rsp.lce_id, rsp.addr},
                           {op, lce_id_t'(port), a});
  endtask

  task automatic begin_test();
    test_errors_at = errors;
  endtask

  task automatic end_test(string name);
    tests_run++;
    if (errors != test_errors_at)
      tests_failed++;
    $display("test %-22s %s (%0d errors)", name,
             (errors == test_errors_at) ? "ok" : "failed", errors - test_errors_at);
  endtask

  initial
  begin
    mem_msg_t rsp;
    data_t    t_prev;
    int       t;
    arst_n_i         = 1'b0;
    proc_cmd_i       = '0;
    proc_cmd_v_i     = '0;
    proc_resp_yumi_i = '0;
    dev_ready        = 2'b11;
    dev_rsp          = '0;
    dev_rsp_v        = '0;
    repeat (16) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(negedge clk_i);

    begin_test();
    rst_ready_a: assert (proc_cmd_ready_o == 3'b111)
      else report_mismatch("proc_cmd_ready_o", proc_cmd_ready_o, 3'b111);
    rst_valid_a: assert (proc_resp_v_o == 3'b000 && dev_cmd_v == 2'b00)
      else report_mismatch("valid outputs", {proc_resp_v_o, dev_cmd_v}, 0);
    rst_irq_a: assert (!timer_irq_o && !software_irq_o)
      else report_mismatch("interrupts", {timer_irq_o, software_irq_o}, 0);
    end_test("reset state");

    begin_test();
    for (int p = 0; p < 3; p++)
    begin
      issue(p, e_mem_wr, dram_base_c + paddr_t'(p * 64), 64'h1111_0000_0000_0000 + p);
      issue(p, e_mem_rd, dram_base_c + paddr_t'(p * 64), '0);
      issue(p, e_mem_rd, {16'h0, cache_dev_c, 20'h00100} + paddr_t'(p * 8), '0);
    end
    wait_idle(500);
    end_test("memory routing");

    begin_test();
    for (int p = 0; p < 3; p++)
    begin
      issue(p, e_mem_wr, {16'h0, host_dev_c, 20'h00040} + paddr_t'(p * 8), 64'hABCD + p);
      issue(p, e_mem_rd, {16'h0, host_dev_c, 20'h00080} + paddr_t'(p * 8), '0);
    end
    wait_idle(500);
    end_test("io routing");

    begin_test();
    for (int p = 0; p < 3; p++)
    begin
      issue(p, e_mem_rd, 40'h00_0000_1230 + paddr_t'(p * 8), 64'h77);
      issue(p, e_mem_rd, 40'h00_0050_0040 + paddr_t'(p * 8), 64'h99);
    end
    wait_idle(500);
    end_test("loopback");

    begin_test();
    clint_access(1, e_mem_rd, clint_mtimecmp_c, '0, rsp);
    mtimecmp_rst_a: assert (rsp.data == {64{1'b1}})
      else report_mismatch("mtimecmp", rsp.data, {64{1'b1}});
    clint_access(1, e_mem_wr, clint_msip_c, 64'd1, rsp);
    msip_echo_a: assert (rsp.data == 64'd1) else report_mismatch("msip write data", rsp.data, 1);
    sw_set_a: assert (software_irq_o) else report_mismatch("software_irq_o", software_irq_o, 1);
    clint_access(0, e_mem_rd, clint_msip_c, '0, rsp);
    msip_read_a: assert (rsp.data == 64'd1) else report_mismatch("msip", rsp.data, 1);
    clint_access(2, e_mem_wr, clint_msip_c, 64'd0, rsp);
    sw_clear_a: assert (!software_irq_o) else report_mismatch("software_irq_o", software_irq_o, 0);
    clint_access(1, e_mem_rd, clint_mtime_c, '0, rsp);
    t_prev = rsp.data;
    for (int k = 0; k < 4; k++)
    begin
      clint_access(k % 3, e_mem_rd, clint_mtime_c, '0, rsp);
      mtime_mono_a: assert (rsp.data >= t_prev) else report_mismatch("mtime", rsp.data, t_prev);
      t_prev = rsp.data;
    end
    clint_access(1, e_mem_wr, clint_mtimecmp_c, t_prev + 64, rsp);
    timer_low_a: assert (!timer_irq_o) else report_mismatch("timer_irq_o", timer_irq_o, 0);
    t = 0;
    while (!timer_irq_o && t < 200)
    begin
      @(negedge clk_i);
      t++;
    end
    timer_rise_a: assert (timer_irq_o)
      else report_failure("timer_irq_o did not rise within 200 cycles");
    clint_access(0, e_mem_wr, clint_mtimecmp_c, {64{1'b1}}, rsp);
    timer_clear_a: assert (!timer_irq_o) else report_mismatch("timer_irq_o", timer_irq_o, 0);
    wait_idle(500);
    end_test("clint");

    begin_test();
    rand_bp = 1'b1;
    for (int n = 0; n < 180; n++)
    begin
      t = int'(rand_bits(2)) % 3;
      issue(t, mem_op_e'(rand_bits(1)), rand_addr(), rand_bits(64));
      if (rand_bits(2) == 64'd0)
        @(negedge clk_i);
    end
    wait_idle(20000);
    rand_bp = 1'b0;
    end_test("back-pressure and order");

    $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* uc_uncore.f */
rtl/uc_mem_pkg.sv
rtl/uc_two_fifo.sv
rtl/uc_cmd_router.sv
rtl/uc_resp_router.sv
rtl/uc_clint.sv
rtl/uc_loopback.sv
rtl/uc_uncore.sv
testbench/tb_uc_uncore.sv
